//--- source/ConsolePkg.sv
package ConsolePkg;

    // one character cell, also one received UART byte
    typedef logic [7:0] CharCode_t;

    // parser modes
    // Clearing sweeps the whole screen with spaces, bytes are dropped meanwhile
    typedef enum logic [1:0] {
        Clearing,
        Ground,
        Escape,
        CsiParam
    } ParserState_e;

    // control characters the parser reacts to
    localparam CharCode_t CHAR_ESC   = 8'h1B;
    localparam CharCode_t CHAR_CR    = 8'h0D;
    localparam CharCode_t CHAR_LF    = 8'h0A;
    localparam CharCode_t CHAR_BS    = 8'h08;

    // blank cell fill
    localparam CharCode_t CHAR_SPACE = 8'h20;

endpackage

//--- source/TextRamPort.sv
`timescale 1ns/100ps

interface TextRamPort #(
    parameter int ADDR_WIDTH = 7
);
    import ConsolePkg::*;

    // cell index, row * COLS + col
    logic [ADDR_WIDTH-1:0] address;
    CharCode_t             wrData;
    logic                  wrEn;
    // registered, one cycle after address
    CharCode_t             rdData;

    modport parser (
        output address,
        output wrData,
        output wrEn,
        input  rdData
    );

    modport memory (
        input  address,
        input  wrData,
        input  wrEn,
        output rdData
    );

endinterface

//--- source/UartReceiver.sv
`timescale 1ns/100ps

module UartReceiver #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rx,
    output ConsolePkg::CharCode_t rxData,
    output logic                 rxReady
);
    import ConsolePkg::*;

    localparam int COUNT_WIDTH = $clog2(CLKS_PER_BIT);

    // two-flop synchronizer plus one stage for edge detect
    logic rxMeta;
    logic rxSync;
    logic rxPrev;

    logic                   busy;
    logic [COUNT_WIDTH-1:0] clkCount;
    // 0 start, 1..8 data, 9 stop
    logic [3:0]             bitIndex;
    CharCode_t              shiftReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
            rxPrev <= 1'b1;
        end else begin
            rxMeta <= rx;
            rxSync <= rxMeta;
            rxPrev <= rxSync;
        end
    end

    always_ff @(posedge clk) begin
        rxReady <= 1'b0;
        if (rst) begin
            busy     <= 1'b0;
            clkCount <= '0;
            bitIndex <= '0;
        end else if (!busy) begin
            // falling edge starts a frame, first wait is half a bit
            if (rxPrev && !rxSync) begin
                busy     <= 1'b1;
                clkCount <= COUNT_WIDTH'(CLKS_PER_BIT / 2 - 1);
                bitIndex <= '0;
            end
        end else if (clkCount != '0) begin
            clkCount <= clkCount - 1'b1;
        end else begin
            // bit midpoint reached
            clkCount <= COUNT_WIDTH'(CLKS_PER_BIT - 1);
            bitIndex <= bitIndex + 1'b1;
            if (bitIndex == 4'd0) begin
                // glitch, not a real start bit
                if (rxSync) begin
                    busy <= 1'b0;
                end
            end else if (bitIndex <= 4'd8) begin
                // lsb first
                shiftReg <= {rxSync, shiftReg[7:1]};
            end else begin
                busy <= 1'b0;
                // framing error drops the byte silently
                if (rxSync) begin
                    rxData  <= shiftReg;
                    rxReady <= 1'b1;
                end
            end
        end
    end

endmodule

//--- source/Vt100Parser.sv
`timescale 1ns/100ps

module Vt100Parser #(
    parameter int ROWS = 8,
    parameter int COLS = 16
) (
    input  logic                      clk,
    input  logic                      rst,
    input  ConsolePkg::CharCode_t     rxData,
    input  logic                      rxReady,
    TextRamPort.parser                ram,
    output logic [$clog2(ROWS)-1:0]   cursorRow,
    output logic [$clog2(COLS)-1:0]   cursorCol
);
    import ConsolePkg::*;

    localparam int ROW_WIDTH  = $clog2(ROWS);
    localparam int COL_WIDTH  = $clog2(COLS);
    localparam int ADDR_WIDTH = $clog2(ROWS * COLS);
    localparam logic [ADDR_WIDTH-1:0] LAST_CELL = ADDR_WIDTH'(ROWS * COLS - 1);

    ParserState_e          state;
    logic [ADDR_WIDTH-1:0] clearAddr;
    logic [ADDR_WIDTH-1:0] cursorAddress;
    // CSI parameters, saturating decimal
    logic [7:0]            param0;
    logic [7:0]            param1;
    logic                  paramIndex;

    logic       isPrintable;
    logic       isDigit;
    logic [3:0] digit;

    // decimal shift-in with saturation at 255
    function automatic logic [7:0] accumulate(input logic [7:0] p, input logic [3:0] d);
        logic [11:0] sum;
        sum = 12'(p) * 12'd10 + 12'(d);
        return (sum > 12'd255) ? 8'd255 : sum[7:0];
    endfunction

    // 1-based parameter to 0-based index, 0 counts as 1, clamp to limit
    function automatic logic [7:0] toIndex(input logic [7:0] p, input int limit);
        logic [7:0] v;
        v = (p == 8'd0) ? 8'd1 : p;
        if (v > limit) begin
            v = limit[7:0];
        end
        return v - 8'd1;
    endfunction

    assign cursorAddress = ADDR_WIDTH'(cursorRow * COLS + cursorCol);
    assign isPrintable   = (rxData >= 8'h20) && (rxData <= 8'h7E);
    assign isDigit       = (rxData >= "0") && (rxData <= "9");
    assign digit         = 4'(rxData - "0");

    always_ff @(posedge clk) begin
        ram.wrEn <= 1'b0;
        if (rst) begin
            state      <= Clearing;
            clearAddr  <= '0;
            cursorRow  <= '0;
            cursorCol  <= '0;
            paramIndex <= 1'b0;
        end else begin
            case (state)
                Clearing: begin
                    // one blank cell per cycle, incoming bytes dropped
                    ram.wrEn    <= 1'b1;
                    ram.address <= clearAddr;
                    ram.wrData  <= CHAR_SPACE;
                    clearAddr   <= clearAddr + 1'b1;
                    if (clearAddr == LAST_CELL) begin
                        state     <= Ground;
                        cursorRow <= '0;
                        cursorCol <= '0;
                    end
                end
                Ground: if (rxReady) begin
                    if (isPrintable) begin
                        ram.wrEn    <= 1'b1;
                        ram.address <= cursorAddress;
                        ram.wrData  <= rxData;
                        // advance with column and row wrap, no scrolling
                        if (cursorCol == COL_WIDTH'(COLS - 1)) begin
                            cursorCol <= '0;
                            if (cursorRow == ROW_WIDTH'(ROWS - 1)) begin
                                cursorRow <= '0;
                            end else begin
                                cursorRow <= cursorRow + 1'b1;
                            end
                        end else begin
                            cursorCol <= cursorCol + 1'b1;
                        end
                    end else if (rxData == CHAR_CR) begin
                        cursorCol <= '0;
                    end else if (rxData == CHAR_LF) begin
                        if (cursorRow == ROW_WIDTH'(ROWS - 1)) begin
                            cursorRow <= '0;
                        end else begin
                            cursorRow <= cursorRow + 1'b1;
                        end
                    end else if (rxData == CHAR_BS) begin
                        if (cursorCol != '0) begin
                            cursorCol <= cursorCol - 1'b1;
                        end
                    end else if (rxData == CHAR_ESC) begin
                        state <= Escape;
                    end
                end
                Escape: if (rxReady) begin
                    param0     <= 8'd0;
                    param1     <= 8'd0;
                    paramIndex <= 1'b0;
                    state      <= (rxData == "[") ? CsiParam : Ground;
                end
                CsiParam: if (rxReady) begin
                    if (isDigit) begin
                        if (!paramIndex) begin
                            param0 <= accumulate(param0, digit);
                        end else begin
                            param1 <= accumulate(param1, digit);
                        end
                    end else if (rxData == ";") begin
                        // a third parameter folds into the second
                        paramIndex <= 1'b1;
                    end else begin
                        // final byte
                        state <= Ground;
                        if (rxData == "H") begin
                            cursorRow <= ROW_WIDTH'(toIndex(param0, ROWS));
                            cursorCol <= COL_WIDTH'(toIndex(param1, COLS));
                        end else if (rxData == "J" && param0 == 8'd2) begin
                            state     <= Clearing;
                            clearAddr <= '0;
                        end
                    end
                end
                default: state <= Ground;
            endcase
        end
    end

endmodule

//--- source/TextRam.sv
`timescale 1ns/100ps

module TextRam #(
    parameter int ROWS = 8,
    parameter int COLS = 16
) (
    input  logic                           clk,
    TextRamPort.memory                     ram,
    input  logic [$clog2(ROWS*COLS)-1:0]   readAddress,
    output ConsolePkg::CharCode_t          readChar
);
    import ConsolePkg::*;

    localparam int CELLS = ROWS * COLS;

    CharCode_t cells [CELLS];

    // parser port, read returns the old value on a same-cycle write
    always_ff @(posedge clk) begin
        if (ram.wrEn) begin
            cells[ram.address] <= ram.wrData;
        end
        ram.rdData <= cells[ram.address];
    end

    // renderer port, read only
    always_ff @(posedge clk) begin
        readChar <= cells[readAddress];
    end

endmodule

//--- source/FpgaVirtualConsole.sv
`timescale 1ns/100ps

module FpgaVirtualConsole #(
    parameter int CLKS_PER_BIT = 16,
    parameter int ROWS         = 8,
    parameter int COLS         = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    // serial input from host
    input  logic                           uartRx,
    // renderer read port
    input  logic [$clog2(ROWS*COLS)-1:0]   readAddress,
    output ConsolePkg::CharCode_t          readChar,
    // cursor position
    output logic [$clog2(ROWS)-1:0]        cursorRow,
    output logic [$clog2(COLS)-1:0]        cursorCol
);
    import ConsolePkg::*;

    localparam int ADDR_WIDTH = $clog2(ROWS * COLS);

    CharCode_t rxData;
    logic      rxReady;

    TextRamPort #(.ADDR_WIDTH(ADDR_WIDTH)) parserPort();

    UartReceiver #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) uartReceiver (
        .clk,
        .rst,
        .rx(uartRx),
        .rxData,
        .rxReady
    );

    Vt100Parser #(
        .ROWS(ROWS),
        .COLS(COLS)
    ) vt100Parser (
        .clk,
        .rst,
        .rxData,
        .rxReady,
        .ram(parserPort.parser),
        .cursorRow,
        .cursorCol
    );

    TextRam #(
        .ROWS(ROWS),
        .COLS(COLS)
    ) textRam (
        .clk,
        .ram(parserPort.memory),
        .readAddress,
        .readChar
    );

endmodule

//--- bench/ConsoleBench.sv
`timescale 1ns/100ps

module ConsoleBench;
    import ConsolePkg::*;

    localparam int CLKS_PER_BIT    = 16;
    localparam int ROWS            = 8;
    localparam int COLS            = 16;
    localparam int CELLS           = ROWS * COLS;
    localparam int NUM_ITEMS       = 250;
    localparam int WATCHDOG_CYCLES = 400000;

    // model parser modes
    localparam int M_GROUND = 0;
    localparam int M_ESCAPE = 1;
    localparam int M_CSI    = 2;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     uartRx;
    logic [$clog2(CELLS)-1:0] readAddress;
    CharCode_t                readChar;
    logic [$clog2(ROWS)-1:0]  cursorRow;
    logic [$clog2(COLS)-1:0]  cursorCol;

    // reference screen and parser state
    CharCode_t screen [CELLS];
    int        curRow;
    int        curCol;
    int        mState;
    int        p0;
    int        p1;
    int        pIdx;

    FpgaVirtualConsole #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .ROWS(ROWS),
        .COLS(COLS)
    ) u_dut (
        .clk,
        .rst,
        .uartRx,
        .readAddress,
        .readChar,
        .cursorRow,
        .cursorCol
    );

    always #5 clk = ~clk;

    function automatic int cellAddress(input int row, input int col);
        return row * COLS + col;
    endfunction

    // 1-based parameter to 0-based index
    // zero or missing reads as 1 and large values clamp to the screen
    function automatic int clampIndex(input int p, input int limit);
        if (p == 0) begin
            return 0;
        end
        if (p > limit) begin
            return limit - 1;
        end
        return p - 1;
    endfunction

    task automatic checkValue(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("ERR %s expected %0h actual %0h", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic waitCycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
        end
    endtask

    // cursor gets two bit times to settle
    task automatic waitCursor(input string name);
        logic matched;
        int   limit;
        matched = 1'b0;
        limit   = 2 * CLKS_PER_BIT;
        for (int i = 0; i < limit && !matched; i++) begin
            @(negedge clk);
            matched = (cursorRow == curRow) && (cursorCol == curCol);
        end
        if (!matched) begin
            $display("timeout: cursor did not settle within %0d cycles", limit);
        end
        checkValue({name, " row"}, curRow, cursorRow);
        checkValue({name, " col"}, curCol, cursorCol);
    endtask

    task automatic readCell(input int addr, output CharCode_t value);
        @(posedge clk);
        readAddress <= addr[$clog2(CELLS)-1:0];
        @(posedge clk);
        @(negedge clk);
        value = readChar;
    endtask

    task automatic compareScreen(input string name);
        CharCode_t value;
        for (int a = 0; a < CELLS; a++) begin
            readCell(a, value);
            checkValue(name, screen[a], value);
        end
    endtask

    // start bit, eight data bits lsb first, stop bit
    task automatic sendFrame(input CharCode_t b, input logic stopBit);
        logic [9:0] bits;
        bits = {stopBit, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            uartRx <= bits[i];
            waitCycles(CLKS_PER_BIT - 1);
        end
        @(posedge clk);
        uartRx <= 1'b1;
    endtask

    task automatic applyModel(input CharCode_t b, output logic wrote, output int addr,
                              output logic cleared);
        wrote   = 1'b0;
        cleared = 1'b0;
        addr    = cellAddress(curRow, curCol);
        case (mState)
            M_GROUND: begin
                if (b >= 8'h20 && b <= 8'h7E) begin
                    screen[addr] = b;
                    wrote        = 1'b1;
                    curCol++;
                    if (curCol == COLS) begin
                        curCol = 0;
                        curRow = (curRow + 1) % ROWS;
                    end
                end else if (b == CHAR_CR) begin
                    curCol = 0;
                end else if (b == CHAR_LF) begin
                    curRow = (curRow + 1) % ROWS;
                end else if (b == CHAR_BS) begin
                    if (curCol > 0) begin
                        curCol--;
                    end
                end else if (b == CHAR_ESC) begin
                    mState = M_ESCAPE;
                end
            end
            M_ESCAPE: begin
                p0     = 0;
                p1     = 0;
                pIdx   = 0;
                mState = (b == "[") ? M_CSI : M_GROUND;
            end
            default: begin
                if (b >= "0" && b <= "9") begin
                    if (pIdx == 0) begin
                        p0 = p0 * 10 + (b - "0");
                    end else begin
                        p1 = p1 * 10 + (b - "0");
                    end
                end else if (b == ";") begin
                    pIdx = 1;
                end else begin
                    mState = M_GROUND;
                    if (b == "H") begin
                        curRow = clampIndex(p0, ROWS);
                        curCol = clampIndex(p1, COLS);
                    end else if (b == "J" && p0 == 2) begin
                        for (int a = 0; a < CELLS; a++) begin
                            screen[a] = CHAR_SPACE;
                        end
                        curRow  = 0;
                        curCol  = 0;
                        cleared = 1'b1;
                    end
                end
            end
        endcase
    endtask

    task automatic sendByte(input CharCode_t b, input string name);
        logic      wrote;
        logic      cleared;
        int        addr;
        CharCode_t value;
        sendFrame(b, 1'b1);
        applyModel(b, wrote, addr, cleared);
        if (cleared) begin
            // sweep writes one cell per cycle
            waitCycles(CELLS + 8);
            compareScreen(name);
        end
        waitCursor(name);
        if (!wrote) begin
            addr = cellAddress(curRow, curCol);
        end
        readCell(addr, value);
        checkValue(name, screen[addr], value);
        waitCycles($urandom_range(4, 1));
    endtask

    task automatic sendNumber(input int n, input string name);
        if (n >= 10) begin
            sendByte(CharCode_t'("0" + n / 10), name);
        end
        sendByte(CharCode_t'("0" + n % 10), name);
    endtask

    task automatic sendCursorPosition();
        int row;
        int col;
        row = $urandom_range(ROWS + 3, 0);
        col = $urandom_range(COLS + 3, 0);
        sendByte(CHAR_ESC, "cursor position");
        sendByte("[", "cursor position");
        // zero is sent as a digit or left out
        if (row != 0 || $urandom_range(1, 0) == 1) begin
            sendNumber(row, "cursor position");
        end
        if (col != 0 || $urandom_range(1, 0) == 1) begin
            sendByte(";", "cursor position");
            if (col != 0) begin
                sendNumber(col, "cursor position");
            end
        end
        sendByte("H", "cursor position");
    endtask

    task automatic sendUnknownCsi();
        int pick;
        pick = $urandom_range(2, 0);
        sendByte(CHAR_ESC, "unknown csi");
        sendByte("[", "unknown csi");
        if (pick == 0) begin
            sendByte("K", "unknown csi");
        end else if (pick == 1) begin
            sendByte("1", "unknown csi");
            sendByte("J", "unknown csi");
        end else begin
            sendByte("m", "unknown csi");
        end
    endtask

    // byte with a framing error that the dut must ignore
    task automatic sendBadStop();
        int        addr;
        CharCode_t value;
        sendFrame(CharCode_t'($urandom_range(126, 32)), 1'b0);
        waitCursor("bad stop");
        addr = cellAddress(curRow, curCol);
        readCell(addr, value);
        checkValue("bad stop", screen[addr], value);
        waitCycles(CLKS_PER_BIT);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("simulation did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

    initial begin
        int r;
        void'($urandom(54622));
        rst         = 1'b1;
        uartRx      = 1'b1;
        readAddress = '0;
        // expected state once the power-up clear is done
        for (int a = 0; a < CELLS; a++) begin
            screen[a] = CHAR_SPACE;
        end
        curRow = 0;
        curCol = 0;
        mState = M_GROUND;
        p0     = 0;
        p1     = 0;
        pIdx   = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        waitCycles(CELLS + 8);
        compareScreen("reset screen");
        waitCursor("reset cursor");

        for (int item = 0; item < NUM_ITEMS; item++) begin
            r = $urandom_range(99, 0);
            if (r < 60) begin
                sendByte(CharCode_t'($urandom_range(126, 32)), "print");
            end else if (r < 66) begin
                sendByte(CHAR_CR, "carriage return");
            end else if (r < 72) begin
                sendByte(CHAR_LF, "line feed");
            end else if (r < 78) begin
                sendByte(CHAR_BS, "backspace");
            end else if (r < 88) begin
                sendCursorPosition();
            end else if (r < 91) begin
                sendByte(CHAR_ESC, "clear screen");
                sendByte("[", "clear screen");
                sendByte("2", "clear screen");
                sendByte("J", "clear screen");
            end else if (r < 95) begin
                sendByte(CHAR_ESC, "unknown escape");
                sendByte(CharCode_t'($urandom_range(90, 64)), "unknown escape");
            end else if (r < 98) begin
                sendUnknownCsi();
            end else begin
                sendBadStop();
            end
        end

        compareScreen("final screen");
        waitCursor("final cursor");
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- filelist.f
source/ConsolePkg.sv
source/TextRamPort.sv
source/UartReceiver.sv
source/Vt100Parser.sv
source/TextRam.sv
source/FpgaVirtualConsole.sv
bench/ConsoleBench.sv

//--- Bender.yml
package:
  name: fpga_virtual_console

sources:
  - source/ConsolePkg.sv
  - source/TextRamPort.sv
  - source/UartReceiver.sv
  - source/Vt100Parser.sv
  - source/TextRam.sv
  - source/FpgaVirtualConsole.sv
  - target: simulation
    files:
      - bench/ConsoleBench.sv
